// File: design/alu.sv
`include "cpu_defs.svh"
`default_nettype none

module alu (
    input  wire logic [`CPU_XLEN-1:0] a,
    input  wire logic [`CPU_XLEN-1:0] b,
    input  wire cpu_pkg::alu_op_e     op,
    output logic [`CPU_XLEN-1:0]      result,
    output logic                      carry,
    output logic                      sign,
    output logic                      zero
);

    logic [`CPU_XLEN:0] sum;
    logic [`CPU_XLEN:0] diff;
    logic               less;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;  // top bit is the inverted borrow
    assign less = $signed(a) < $signed(b);

    always_comb begin
        carry = 1'b0;
        case (op)
            cpu_pkg::alu_add: begin
                result = sum[`CPU_XLEN-1:0];
                carry  = sum[`CPU_XLEN];
            end
            cpu_pkg::alu_sub: begin
                result = diff[`CPU_XLEN-1:0];
                carry  = diff[`CPU_XLEN];
            end
            cpu_pkg::alu_and: result = a & b;
            cpu_pkg::alu_or:  result = a | b;
            cpu_pkg::alu_xor: result = a ^ b;
            cpu_pkg::alu_shl: result = a << b[4:0];
            cpu_pkg::alu_shr: result = a >> b[4:0];
            cpu_pkg::alu_sra: result = $signed(a) >>> b[4:0];
            cpu_pkg::alu_slt: begin
                result = `CPU_XLEN'(less);
                carry  = diff[`CPU_XLEN];
            end
            default: result = '0;  // unused encodings
        endcase
    end

    assign sign = result[`CPU_XLEN-1];
    assign zero = result == '0;

endmodule

`default_nettype wire

// File: design/bus_arbiter.sv
`default_nettype none

module bus_arbiter (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire cpu_pkg::wb_req_t m0_req,
    input  wire cpu_pkg::wb_req_t m1_req,
    output cpu_pkg::wb_rsp_t      m0_rsp,
    output cpu_pkg::wb_rsp_t      m1_rsp,
    output cpu_pkg::wb_req_t      s_req,
    input  wire cpu_pkg::wb_rsp_t s_rsp
);

    logic locked;  // a master owns the bus until its cyc drops
    logic owner;   // last master granted
    logic sel;

    always_comb begin
        if (locked) begin
            sel = owner;
        end else if (m0_req.cyc && m1_req.cyc) begin
            sel = ~owner;  // round robin
        end else begin
            sel = m1_req.cyc;
        end
    end

    assign s_req = sel ? m1_req : m0_req;

    always_comb begin
        m0_rsp     = s_rsp;
        m1_rsp     = s_rsp;
        m0_rsp.ack = s_rsp.ack && !sel;
        m1_rsp.ack = s_rsp.ack && sel;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            locked <= 1'b0;
            owner  <= 1'b1;  // master 0 wins the first tie
        end else if (locked) begin
            if (!s_req.cyc) locked <= 1'b0;
        end else if (s_req.cyc) begin
            locked <= 1'b1;
            owner  <= sel;
        end
    end

endmodule

`default_nettype wire

// File: design/control_unit.sv
`include "cpu_defs.svh"
`default_nettype none

module control_unit (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 run,
    output cpu_pkg::wb_req_t          bus_req,
    input  wire cpu_pkg::wb_rsp_t     bus_rsp,
    output cpu_pkg::ctrl_t            ctrl,
    output logic                      commit,
    output logic [4:0]                rd,
    output logic [4:0]                rs,
    output logic [4:0]                rt,
    output logic [15:0]               imm,
    output logic [`CPU_XLEN-1:0]      link_value,
    output logic [`CPU_XLEN-1:0]      load_data,
    input  wire logic [`CPU_XLEN-1:0] alu_result,
    input  wire logic [`CPU_XLEN-1:0] store_data,
    input  wire logic [`CPU_XLEN-1:0] rs_value,
    input  wire logic [2:0]           flags,
    output logic                      halted
);

    typedef enum logic [2:0] {
        st_idle, st_fetch, st_decode, st_execute, st_memory, st_writeback, st_halted
    } state_e;

    state_e                    state;
    cpu_pkg::opcode_e          op;
    cpu_pkg::ctrl_t            dec;
    logic [`MEM_ADDR_BITS-1:0] pc;
    logic [`MEM_ADDR_BITS-1:0] pc_plus1;
    logic [`MEM_ADDR_BITS-1:0] pc_target;
    logic [`MEM_ADDR_BITS-1:0] pc_next;
    logic [`CPU_XLEN-1:0]      ir;
    logic                      op_known;
    logic                      is_store;
    logic                      cond_true;

    assign op         = cpu_pkg::opcode_e'(ir[31:26]);
    assign rd         = ir[25:21];
    assign rs         = ir[20:16];
    assign rt         = ir[15:11];
    assign imm        = ir[15:0];
    assign pc_plus1   = pc + 1'b1;
    assign link_value = `CPU_XLEN'(pc_plus1);
    assign is_store   = op == cpu_pkg::op_store;
    assign commit     = state == st_writeback;
    assign halted     = state == st_halted;

    always_comb begin
        dec      = '0;
        op_known = 1'b1;
        case (op)
            cpu_pkg::op_alu_r: begin
                dec.alu_op      = cpu_pkg::alu_op_e'(ir[3:0]);
                dec.reg_write   = 1'b1;
                dec.flags_write = 1'b1;
            end
            cpu_pkg::op_alu_i: begin  // add only
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.flags_write = 1'b1;
            end
            cpu_pkg::op_shift_i: begin
                dec.alu_op       = cpu_pkg::alu_op_e'(ir[3:0]);
                dec.alu_src_imm  = 1'b1;
                dec.imm_is_shift = 1'b1;
                dec.reg_write    = 1'b1;
                dec.flags_write  = 1'b1;
            end
            cpu_pkg::op_load: begin
                dec.alu_src_imm = 1'b1;
                dec.reg_write   = 1'b1;
                dec.wb_sel      = cpu_pkg::wb_load;
            end
            cpu_pkg::op_store: dec.alu_src_imm = 1'b1;  // address is rs + imm
            cpu_pkg::op_jal: begin
                dec.reg_write = 1'b1;
                dec.wb_sel    = cpu_pkg::wb_link;
                dec.dst_sel   = cpu_pkg::dst_link;
            end
            cpu_pkg::op_branch, cpu_pkg::op_jr: ;
            default: op_known = 1'b0;  // halt and unknown opcodes
        endcase
    end

    // condition codes 0 zero, 1 not zero, 2 carry, 3 sign
    always_comb begin
        case (rt[1:0])
            2'd0:    cond_true = flags[0];
            2'd1:    cond_true = !flags[0];
            2'd2:    cond_true = flags[2];
            default: cond_true = flags[1];
        endcase
    end

    always_comb begin
        case (op)
            cpu_pkg::op_branch:
                pc_target = cond_true ? pc_plus1 + imm[`MEM_ADDR_BITS-1:0] : pc_plus1;
            cpu_pkg::op_jal: pc_target = pc_plus1 + imm[`MEM_ADDR_BITS-1:0];
            cpu_pkg::op_jr:  pc_target = rs_value[`MEM_ADDR_BITS-1:0];
            default:         pc_target = pc_plus1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            pc    <= `MEM_ADDR_BITS'(`RESET_PC);
            ctrl  <= '0;
        end else begin
            case (state)
                st_idle:    if (run) state <= st_fetch;
                st_fetch:   if (bus_rsp.ack) state <= st_decode;
                st_decode: begin
                    ctrl  <= dec;
                    state <= op_known ? st_execute : st_halted;
                end
                st_execute: begin
                    state <= (is_store || op == cpu_pkg::op_load) ? st_memory : st_writeback;
                end
                st_memory:  if (bus_rsp.ack) state <= st_writeback;
                st_writeback: begin
                    pc    <= pc_next;
                    state <= st_fetch;
                end
                default: state <= st_halted;  // stays until reset
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_fetch && bus_rsp.ack) ir <= bus_rsp.dat;
        if (state == st_memory && bus_rsp.ack) load_data <= bus_rsp.dat;
        if (state == st_execute) pc_next <= pc_target;
    end

    always_comb begin
        bus_req     = '0;
        bus_req.cyc = state == st_fetch || state == st_memory;
        bus_req.stb = bus_req.cyc;
        bus_req.we  = state == st_memory && is_store;
        bus_req.adr = (state == st_memory) ? alu_result[`MEM_ADDR_BITS-1:0] : pc;
        bus_req.dat = store_data;
    end

endmodule

`default_nettype wire

// File: design/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data and instruction word width
`define CPU_XLEN 32

// word address width of the shared RAM
`define MEM_ADDR_BITS 10

// number of words behind the arbiter
`define MEM_DEPTH_WORDS (1 << `MEM_ADDR_BITS)

// word address of the first instruction
`define RESET_PC 0

// destination of jal
`define LINK_REG 31

`endif

// File: design/cpu_pkg.sv
`include "cpu_defs.svh"
`default_nettype none

package cpu_pkg;

    // opcode in instruction bits 31:26, anything not listed halts the core
    typedef enum logic [5:0] {
        op_alu_r   = 6'h00,  // rd = rs op rt, op in bits 3:0
        op_alu_i   = 6'h01,  // rd = rs + sext(imm)
        op_shift_i = 6'h02,  // rd = rs op imm[10:6], op in bits 3:0
        op_load    = 6'h03,  // rd = mem[rs + sext(imm)]
        op_store   = 6'h04,  // mem[rs + sext(imm)] = rt
        op_branch  = 6'h05,  // if cond(rt[1:0]) pc = pc + 1 + imm
        op_jal     = 6'h06,  // r31 = pc + 1, pc = pc + 1 + imm
        op_jr      = 6'h07,  // pc = rs
        op_halt    = 6'h3f
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_shl = 4'd5,
        alu_shr = 4'd6,
        alu_sra = 4'd7,
        alu_slt = 4'd8
    } alu_op_e;

    typedef enum logic [1:0] {
        wb_alu  = 2'd0,
        wb_load = 2'd1,
        wb_link = 2'd2
    } wb_sel_e;

    typedef enum logic {
        dst_rd   = 1'b0,
        dst_link = 1'b1
    } dst_sel_e;

    typedef struct packed {
        logic                      cyc;
        logic                      stb;
        logic                      we;
        logic [`MEM_ADDR_BITS-1:0] adr;
        logic [`CPU_XLEN-1:0]      dat;
    } wb_req_t;

    typedef struct packed {
        logic                 ack;
        logic [`CPU_XLEN-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        alu_op_e  alu_op;
        logic     alu_src_imm;   // operand b from the immediate
        logic     imm_is_shift;  // immediate is a zero-extended shamt
        logic     reg_write;
        wb_sel_e  wb_sel;
        dst_sel_e dst_sel;
        logic     flags_write;
    } ctrl_t;

endpackage

`default_nettype wire

// File: design/cpu_top.sv
`include "cpu_defs.svh"
`default_nettype none

module cpu_top #(
    parameter int WAIT_STATES = 1
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             run,
    input  wire cpu_pkg::wb_req_t host_req,
    output cpu_pkg::wb_rsp_t      host_rsp,
    output logic                  halted
);

    cpu_pkg::wb_req_t     cpu_req;
    cpu_pkg::wb_rsp_t     cpu_rsp;
    cpu_pkg::wb_req_t     mem_req;
    cpu_pkg::wb_rsp_t     mem_rsp;
    cpu_pkg::ctrl_t       ctrl;
    logic                 commit;
    logic [4:0]           rd;
    logic [4:0]           rs;
    logic [4:0]           rt;
    logic [15:0]          imm;
    logic [`CPU_XLEN-1:0] link_value;
    logic [`CPU_XLEN-1:0] load_data;
    logic [`CPU_XLEN-1:0] alu_result;
    logic [`CPU_XLEN-1:0] store_data;
    logic [`CPU_XLEN-1:0] rs_value;
    logic [2:0]           flags;

    control_unit control_unit_inst (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .bus_req    (cpu_req),
        .bus_rsp    (cpu_rsp),
        .ctrl       (ctrl),
        .commit     (commit),
        .rd         (rd),
        .rs         (rs),
        .rt         (rt),
        .imm        (imm),
        .link_value (link_value),
        .load_data  (load_data),
        .alu_result (alu_result),
        .store_data (store_data),
        .rs_value   (rs_value),
        .flags      (flags),
        .halted     (halted)
    );

    data_path data_path_inst (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .commit     (commit),
        .rd         (rd),
        .rs         (rs),
        .rt         (rt),
        .imm        (imm),
        .link_value (link_value),
        .load_data  (load_data),
        .alu_result (alu_result),
        .store_data (store_data),
        .rs_value   (rs_value),
        .flags      (flags)
    );

    // processor is master 0, host is master 1
    bus_arbiter bus_arbiter_inst (
        .clk    (clk),
        .rst    (rst),
        .m0_req (cpu_req),
        .m1_req (host_req),
        .m0_rsp (cpu_rsp),
        .m1_rsp (host_rsp),
        .s_req  (mem_req),
        .s_rsp  (mem_rsp)
    );

    memory_wb #(
        .WAIT_STATES (WAIT_STATES),
        .DEPTH_WORDS (`MEM_DEPTH_WORDS)
    ) memory_wb_inst (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// File: design/data_path.sv
`include "cpu_defs.svh"
`default_nettype none

module data_path (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire cpu_pkg::ctrl_t       ctrl,
    input  wire logic                 commit,
    input  wire logic [4:0]           rd,
    input  wire logic [4:0]           rs,
    input  wire logic [4:0]           rt,
    input  wire logic [15:0]          imm,
    input  wire logic [`CPU_XLEN-1:0] link_value,
    input  wire logic [`CPU_XLEN-1:0] load_data,
    output logic [`CPU_XLEN-1:0]      alu_result,
    output logic [`CPU_XLEN-1:0]      store_data,
    output logic [`CPU_XLEN-1:0]      rs_value,
    output logic [2:0]                flags
);

    logic [`CPU_XLEN-1:0] rt_value;
    logic [`CPU_XLEN-1:0] imm_ext;
    logic [`CPU_XLEN-1:0] shamt_ext;
    logic [`CPU_XLEN-1:0] operand_b;
    logic [`CPU_XLEN-1:0] wb_value;
    logic [4:0]           waddr;
    logic                 alu_carry;
    logic                 alu_sign;
    logic                 alu_zero;

    assign imm_ext   = {{(`CPU_XLEN-16){imm[15]}}, imm};
    assign shamt_ext = `CPU_XLEN'(imm[10:6]);
    assign operand_b = !ctrl.alu_src_imm ? rt_value :
                       ctrl.imm_is_shift ? shamt_ext : imm_ext;

    always_comb begin
        case (ctrl.wb_sel)
            cpu_pkg::wb_load: wb_value = load_data;
            cpu_pkg::wb_link: wb_value = link_value;
            default:          wb_value = alu_result;
        endcase
    end

    assign waddr = (ctrl.dst_sel == cpu_pkg::dst_link) ? 5'(`LINK_REG) : rd;

    register_file register_file_inst (
        .clk     (clk),
        .rst     (rst),
        .we      (commit && ctrl.reg_write),
        .waddr   (waddr),
        .wdata   (wb_value),
        .raddr_a (rs),
        .raddr_b (rt),
        .rdata_a (rs_value),
        .rdata_b (rt_value)
    );

    alu alu_inst (
        .a      (rs_value),
        .b      (operand_b),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .carry  (alu_carry),
        .sign   (alu_sign),
        .zero   (alu_zero)
    );

    // flags are {carry, sign, zero}
    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= 3'b000;
        end else if (commit && ctrl.flags_write) begin
            flags <= {alu_carry, alu_sign, alu_zero};
        end
    end

    assign store_data = rt_value;

endmodule

`default_nettype wire

// File: design/memory_wb.sv
`include "cpu_defs.svh"
`default_nettype none

module memory_wb #(
    parameter int WAIT_STATES = 1,
    parameter int DEPTH_WORDS = `MEM_DEPTH_WORDS
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire cpu_pkg::wb_req_t req,
    output cpu_pkg::wb_rsp_t      rsp
);

    localparam int CNT_W = $clog2(WAIT_STATES + 2);
    localparam logic [CNT_W-1:0] LAST_WAIT = CNT_W'(WAIT_STATES);

    logic [`CPU_XLEN-1:0] mem [DEPTH_WORDS];
    logic [`CPU_XLEN-1:0] rd_data;
    logic [CNT_W-1:0]     wait_cnt;
    logic                 ack;
    logic                 hit;

    assign hit = req.cyc && req.stb && !ack && wait_cnt == LAST_WAIT;  // last wait cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            ack      <= 1'b0;
            wait_cnt <= '0;
        end else begin
            ack <= hit;
            if (ack || hit || !(req.cyc && req.stb)) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (req.we) mem[req.adr] <= req.dat;
            rd_data <= mem[req.adr];
        end
    end

    assign rsp = '{ack: ack, dat: rd_data};

endmodule

`default_nettype wire

// File: design/register_file.sv
`include "cpu_defs.svh"
`default_nettype none

module register_file (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 we,
    input  wire logic [4:0]           waddr,
    input  wire logic [`CPU_XLEN-1:0] wdata,
    input  wire logic [4:0]           raddr_a,
    input  wire logic [4:0]           raddr_b,
    output logic [`CPU_XLEN-1:0]      rdata_a,
    output logic [`CPU_XLEN-1:0]      rdata_b
);

    logic [`CPU_XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin  // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

`default_nettype wire

// File: test/cpu_tb.sv
`include "cpu_defs.svh"
`default_nettype none

module cpu_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int BODY_LEN       = 40;
    localparam int PROG_LEN       = BODY_LEN + 32;  // body, 31 dump stores, halt
    localparam int PROGS_PER_TEST = 3;
    localparam int NUM_PROGRAMS   = 4 * PROGS_PER_TEST;
    localparam longint WATCHDOG_CYCLES = 64'd2000 * PROG_LEN * NUM_PROGRAMS;
    localparam int DATA_BASE  = 512;
    localparam int DATA_WORDS = 32;
    localparam int DUMP_BASE  = 992;  // r1 lands here and r31 at 1022
    localparam int MODE_ALU  = 0;
    localparam int MODE_MEM  = 1;
    localparam int MODE_FLOW = 2;
    localparam int MODE_ALL  = 3;

    logic             clk;
    logic             rst;
    logic             run;
    cpu_pkg::wb_req_t host_req;
    cpu_pkg::wb_rsp_t host_rsp;
    logic             halted;

    logic [31:0] model_mem [1 << `MEM_ADDR_BITS];
    logic [31:0] model_regs [32];
    logic [2:0]  model_flags;  // carry, sign, zero
    logic [31:0] prog [$];
    bit          held [bit [41:0]];  // every {addr, value} a data word has had
    int          checks;
    int          errors;

    cpu_top cpu_top_inst (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .halted   (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the processor did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0d ns: %s actual %h expected %h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        run = 1'b0;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // one classic cycle on the host port held until ack
    task automatic host_access(input bit we, input logic [9:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        @(posedge clk);
        #1;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = addr;
        host_req.dat = wdata;
        do begin
            @(posedge clk);
            #1;
        end while (!host_rsp.ack);
        rdata    = host_rsp.dat;
        host_req = '0;
    endtask

    task automatic wait_halted();
        do begin
            @(posedge clk);
            #1;
        end while (!halted);
    endtask

    function automatic logic [31:0] encode(input logic [5:0] opc, input logic [4:0] rd,
                                           input logic [4:0] rs, input logic [15:0] low);
        return {opc, rd, rs, low};
    endfunction

    // returns {carry, result}
    function automatic logic [32:0] alu_eval(input logic [3:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        logic [32:0] sum;
        logic [31:0] sra;
        logic        no_borrow;
        sum       = {1'b0, a} + {1'b0, b};
        sra       = $signed(a) >>> b[4:0];
        no_borrow = a >= b;
        case (op)
            cpu_pkg::alu_add: return sum;
            cpu_pkg::alu_sub: return {no_borrow, a - b};
            cpu_pkg::alu_and: return {1'b0, a & b};
            cpu_pkg::alu_or:  return {1'b0, a | b};
            cpu_pkg::alu_xor: return {1'b0, a ^ b};
            cpu_pkg::alu_shl: return {1'b0, a << b[4:0]};
            cpu_pkg::alu_shr: return {1'b0, a >> b[4:0]};
            cpu_pkg::alu_sra: return {1'b0, sra};
            cpu_pkg::alu_slt: return {no_borrow, 31'd0, $signed(a) < $signed(b)};
            default:          return 33'd0;
        endcase
    endfunction

    task automatic write_result(input logic [4:0] rd, input logic [32:0] res,
                                input bit set_flags);
        if (rd != 5'd0) model_regs[rd] = res[31:0];
        if (set_flags) model_flags = {res[32], res[31], res[31:0] == 32'd0};
    endtask

    // instruction-set model that runs the loaded image to halt
    task automatic run_model();
        logic [9:0]  pc;
        logic [31:0] ir;
        logic [31:0] a;
        logic [31:0] b;
        logic [9:0]  addr;
        logic        take;
        int          steps;
        bit          done;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        model_flags = 3'b000;
        pc    = 10'(`RESET_PC);
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 4 * PROG_LEN) begin
            ir   = model_mem[pc];
            a    = model_regs[ir[20:16]];
            b    = model_regs[ir[15:11]];
            addr = 10'(a + {{16{ir[15]}}, ir[15:0]});
            steps++;
            case (ir[31:26])
                cpu_pkg::op_alu_r:   write_result(ir[25:21], alu_eval(ir[3:0], a, b), 1'b1);
                cpu_pkg::op_alu_i: begin
                    write_result(ir[25:21], alu_eval(cpu_pkg::alu_add, a,
                                 {{16{ir[15]}}, ir[15:0]}), 1'b1);
                end
                cpu_pkg::op_shift_i: begin
                    write_result(ir[25:21], alu_eval(ir[3:0], a, 32'(ir[10:6])), 1'b1);
                end
                cpu_pkg::op_load:    write_result(ir[25:21], {1'b0, model_mem[addr]}, 1'b0);
                cpu_pkg::op_store: begin
                    model_mem[addr] = b;
                    held[{addr, b}] = 1'b1;
                end
                cpu_pkg::op_branch: begin
                    case (ir[12:11])
                        2'd0:    take = model_flags[0];
                        2'd1:    take = !model_flags[0];
                        2'd2:    take = model_flags[2];
                        default: take = model_flags[1];
                    endcase
                end
                cpu_pkg::op_jal:     model_regs[`LINK_REG] = 32'(pc + 10'd1);
                cpu_pkg::op_jr: ;
                default: done = 1'b1;  // halt or unknown opcode
            endcase
            if (ir[31:26] == cpu_pkg::op_jr) pc = a[9:0];
            else if (ir[31:26] == cpu_pkg::op_jal || (ir[31:26] == cpu_pkg::op_branch && take))
                pc = pc + 10'd1 + ir[9:0];
            else if (!done) pc = pc + 10'd1;
        end
        if (!done) begin
            errors++;
            $display("model error: program at %0d ns never reached its halt", $time);
        end
    endtask

    // target of the jump in slot j, or -1 if slot j does not jump
    function automatic int jump_target(input int j);
        case (prog[j][31:26])
            cpu_pkg::op_branch, cpu_pkg::op_jal: return j + 1 + int'(prog[j][9:0]);
            cpu_pkg::op_jr:                      return int'(prog[j - 1][9:0]);
            default:                             return -1;
        endcase
    endfunction

    task automatic gen_program(input int mode);
        int         kinds [$];
        int         kind;
        int         pos;
        int         off;
        logic [4:0] r;
        kinds = '{0, 1, 2};
        if (mode == MODE_MEM || mode == MODE_ALL) kinds = {kinds, 3, 4, 3, 4};
        if (mode == MODE_FLOW || mode == MODE_ALL) kinds = {kinds, 5, 6, 7, 5};
        prog.delete();
        while (prog.size() < BODY_LEN) begin
            pos  = prog.size();
            kind = kinds[$urandom_range(kinds.size() - 1, 0)];
            if (kind == 7 && pos + 2 > BODY_LEN) kind = 1;  // jr pair needs two slots
            if (kind == 7) begin
                // an earlier jump onto the jr would skip its register setup
                for (int j = 0; j < pos; j++) begin
                    if (jump_target(j) == pos + 1) kind = 1;
                end
            end
            off = $urandom_range((BODY_LEN - pos - 1 < 4) ? BODY_LEN - pos - 1 : 4, 0);
            case (kind)
                0: prog.push_back(encode(cpu_pkg::op_alu_r, 5'($urandom), 5'($urandom),
                                         {5'($urandom), 7'd0, 4'($urandom_range(8, 0))}));
                1: prog.push_back(encode(cpu_pkg::op_alu_i, 5'($urandom), 5'($urandom),
                                         16'($urandom)));
                2: prog.push_back(encode(cpu_pkg::op_shift_i, 5'($urandom), 5'($urandom),
                                         {5'd0, 5'($urandom), 2'd0,
                                          4'($urandom_range(7, 5))}));  // shl, shr, sra
                3: prog.push_back(encode(cpu_pkg::op_load, 5'($urandom), 5'd0,
                                         16'(DATA_BASE + $urandom_range(DATA_WORDS - 1, 0))));
                4: prog.push_back(encode(cpu_pkg::op_store, 5'd0, 5'd0,
                                         {5'($urandom), 1'b0,
                                          10'(DATA_BASE + $urandom_range(DATA_WORDS - 1, 0))}));
                5: prog.push_back(encode(cpu_pkg::op_branch, 5'd0, 5'd0,
                                         {3'd0, 2'($urandom), 1'b0, 10'(off)}));
                6: prog.push_back(encode(cpu_pkg::op_jal, 5'd0, 5'd0, 16'(off)));
                default: begin
                    // absolute forward target built in a register before the jr
                    r   = 5'($urandom_range(31, 1));
                    off = $urandom_range((BODY_LEN - pos - 2 < 3) ? BODY_LEN - pos - 2 : 3, 0);
                    prog.push_back(encode(cpu_pkg::op_alu_i, r, 5'd0, 16'(pos + 2 + off)));
                    prog.push_back(encode(cpu_pkg::op_jr, 5'd0, r, 16'd0));
                end
            endcase
        end
        for (int i = 1; i < 32; i++) begin
            prog.push_back(encode(cpu_pkg::op_store, 5'd0, 5'd0,
                                  {5'(i), 1'b0, 10'(DUMP_BASE + i - 1)}));
        end
        // the mixed programs end on an unassigned opcode instead of halt
        prog.push_back(encode((mode == MODE_ALL) ? 6'h2a : cpu_pkg::op_halt, 5'd0, 5'd0, 16'd0));
    endtask

    task automatic load_memory();
        logic [31:0] v;
        logic [31:0] unused;
        held.delete();
        for (int a = DATA_BASE; a < DATA_BASE + DATA_WORDS; a++) begin
            v            = $urandom;
            model_mem[a] = v;
            held[{10'(a), v}] = 1'b1;
            host_access(1'b1, 10'(a), v, unused);
        end
        foreach (prog[i]) begin
            model_mem[i] = prog[i];
            host_access(1'b1, 10'(i), prog[i], unused);
        end
    endtask

    task automatic run_program(input int mode, input bit host_traffic);
        logic [31:0] v;
        logic [9:0]  a;
        apply_reset();
        gen_program(mode);
        load_memory();
        run_model();
        @(posedge clk);
        #1;
        run = 1'b1;
        while (host_traffic && !halted) begin
            a = 10'(DATA_BASE + $urandom_range(DATA_WORDS - 1, 0));
            host_access(1'b0, a, 32'd0, v);
            checks++;
            if ($isunknown(v) || !held.exists({a, v})) begin
                errors++;
                $display("host read of word %0d during the run returned %h, never held there",
                         a, v);
            end
        end
        wait_halted();
        for (int i = 1; i < 32; i++) begin
            host_access(1'b0, 10'(DUMP_BASE + i - 1), 32'd0, v);
            check_value($sformatf("r%0d", i), v, model_regs[i]);
        end
        if (mode == MODE_MEM || mode == MODE_ALL) begin
            for (int i = DATA_BASE; i < DATA_BASE + DATA_WORDS; i++) begin
                host_access(1'b0, 10'(i), 32'd0, v);
                check_value($sformatf("mem[%0d]", i), v, model_mem[i]);
            end
        end
        check_value("halted", 32'(halted), 32'd1);  // still high after the dump reads
    endtask

    task automatic memory_test();
        logic [9:0]  addrs [$];
        logic [31:0] vals [$];
        logic [31:0] v;
        int          last [$];
        addrs = '{10'd0, 10'd1023};
        repeat (16) addrs.push_back(10'($urandom));
        foreach (addrs[i]) begin
            vals.push_back($urandom);
            host_access(1'b1, addrs[i], vals[i], v);
        end
        foreach (addrs[i]) begin
            last = addrs.find_last_index(x) with (x == addrs[i]);
            if (last[0] == i) begin
                host_access(1'b0, addrs[i], 32'd0, v);
                check_value($sformatf("mem[%0d]", addrs[i]), v, vals[i]);
            end
        end
    endtask

    task automatic report_test(input int num, input string what, input int mark);
        $display("test %0d, %s: finished with %0d errors", num, what, errors - mark);
    endtask

    initial begin
        int mark;
        rst      = 1'b1;
        run      = 1'b0;
        host_req = '0;
        checks   = 0;
        errors   = 0;
        void'($urandom(32'h207f));
        apply_reset();

        mark = errors;
        check_value("halted", 32'(halted), 32'd0);
        memory_test();
        report_test(1, "reset and host memory access", mark);

        mark = errors;
        repeat (PROGS_PER_TEST) run_program(MODE_ALU, 1'b0);
        report_test(2, "alu register and immediate programs", mark);

        mark = errors;
        repeat (PROGS_PER_TEST) run_program(MODE_MEM, 1'b0);
        report_test(3, "load and store programs", mark);

        mark = errors;
        repeat (PROGS_PER_TEST) run_program(MODE_FLOW, 1'b0);
        report_test(4, "branch, jal and jr programs", mark);

        mark = errors;
        repeat (PROGS_PER_TEST) run_program(MODE_ALL, 1'b1);
        report_test(5, "host reads during a run", mark);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+design
design/cpu_pkg.sv
design/alu.sv
design/register_file.sv
design/data_path.sv
design/control_unit.sv
design/bus_arbiter.sv
design/memory_wb.sv
design/cpu_top.sv
test/cpu_tb.sv
